//--- hw/rvCorePkg.sv
// Datapath widths, ALU operation codes, opcode bit position
// Instruction-word union with I, S, B and J views
`default_nettype none

package rvCorePkg;

  localparam int XLEN       = 32;  // Datapath word width
  localparam int REG_ADDR_W = 5;   // Register index width

  // ALU codes, bit 2 doubles as the subtract select
  localparam logic [2:0] ALU_AND = 3'b000;
  localparam logic [2:0] ALU_OR  = 3'b001;
  localparam logic [2:0] ALU_ADD = 3'b010;
  localparam logic [2:0] ALU_SUB = 3'b110;
  localparam logic [2:0] ALU_SLT = 3'b111;

  // Opcode bit 5 set for stores, picks S immediate over I
  localparam int OPC_STORE_BIT = 5;

  // One instruction word, four decodings of the same bits
  typedef union packed {
    struct packed {
      logic [11:0]           imm12;   // ALU-immediate and load offset
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } iView;
    struct packed {
      logic [6:0]            immHi;   // Offset bits 11..5
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            immLo;   // Offset bits 4..0
      logic [6:0]            opcode;
    } sView;
    struct packed {
      logic                  sign;    // Offset bit 12
      logic [5:0]            imm10to5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm4to1;
      logic                  imm11;   // Sits where rd[0] would be
      logic [6:0]            opcode;
    } bView;
    struct packed {
      logic                  sign;    // Offset bit 20
      logic [9:0]            imm10to1;
      logic                  imm11;
      logic [7:0]            imm19to12;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } jView;
  } insnWordT;

endpackage

`default_nettype wire

//--- hw/aluUnit.sv
// ALU with AND, OR, ADD, SUB and signed SLT
// Zero flag on an all-zero result
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  logic [rvCorePkg::XLEN-1:0] a,
  input  logic [rvCorePkg::XLEN-1:0] b,
  input  logic [2:0]                 aluOp,
  output logic [rvCorePkg::XLEN-1:0] result,
  output logic                       zero
);

  import rvCorePkg::*;

  logic            subtract;  // Set for SUB and SLT
  logic [XLEN-1:0] bOperand;  // b or its ones complement
  logic [XLEN-1:0] sum;       // Shared add/sub result
  logic            signsDiffer;
  logic            lessThan;

  // Bit 2 of the code marks the subtracting operations
  assign subtract = aluOp[2];

  // Two's complement subtract, invert b and carry in one
  assign bOperand = subtract ? ~b : b;
  assign sum      = a + bOperand + {{(XLEN-1){1'b0}}, subtract};

  // Signed compare without an overflow flag
  // Mixed signs, a is smaller exactly when a is negative
  // Equal signs, a - b cannot overflow so its sign decides
  assign signsDiffer = a[XLEN-1] ^ b[XLEN-1];
  assign lessThan    = signsDiffer ? a[XLEN-1] : sum[XLEN-1];

  always_comb begin
    case (aluOp)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = sum;
      ALU_SUB: result = sum;  // Same adder, b inverted
      ALU_SLT: result = {{(XLEN-1){1'b0}}, lessThan};
      default: result = '0;   // Unused codes
    endcase
  end

  // Drives the branch decision in fetch
  assign zero = ~|result;

endmodule

`default_nettype wire

//--- hw/immGen.sv
// Sign-extended immediates for I and S formats
// Branch and jump offsets with the implied zero low bit
`timescale 1ns/1ps
`default_nettype none

module immGen (
  input  rvCorePkg::insnWordT        ins,
  output logic [rvCorePkg::XLEN-1:0] immOut,
  output logic [rvCorePkg::XLEN-1:0] branchOff,
  output logic [rvCorePkg::XLEN-1:0] jumpOff
);

  import rvCorePkg::*;

  logic [XLEN-1:0] iImm;     // Loads and ALU immediates
  logic [XLEN-1:0] sImm;     // Store offset
  logic            isStore;

  // 12-bit field, top bit is the sign
  assign iImm = {{(XLEN-12){ins.iView.imm12[11]}}, ins.iView.imm12};

  // Store offset split around rs2/rs1
  assign sImm = {{(XLEN-12){ins.sView.immHi[6]}},
                 ins.sView.immHi,
                 ins.sView.immLo};

  // Only the store opcode sets bit 5 among I/S users
  assign isStore = ins.iView.opcode[OPC_STORE_BIT];
  assign immOut  = isStore ? sImm : iImm;

  // 13-bit branch offset, bit 0 always zero
  assign branchOff = {{(XLEN-13){ins.bView.sign}},
                      ins.bView.sign,
                      ins.bView.imm11,      // Taken from bit 7
                      ins.bView.imm10to5,
                      ins.bView.imm4to1,
                      1'b0};

  // 21-bit jump offset, bit 0 always zero
  assign jumpOff = {{(XLEN-21){ins.jView.sign}},
                    ins.jView.sign,
                    ins.jView.imm19to12,
                    ins.jView.imm11,        // Taken from bit 20
                    ins.jView.imm10to1,
                    1'b0};

endmodule

`default_nettype wire

//--- hw/regFile.sv
// 32-entry register file, two async read ports, one sync write
// x0 held at zero
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       regWrite,
  input  rvCorePkg::insnWordT        ins,
  input  logic [rvCorePkg::XLEN-1:0] wd,
  output logic [rvCorePkg::XLEN-1:0] rd1,
  output logic [rvCorePkg::XLEN-1:0] rd2
);

  import rvCorePkg::*;

  localparam int NUM_REGS = 1 << REG_ADDR_W;

  logic [XLEN-1:0]       regs [NUM_REGS];
  logic [REG_ADDR_W-1:0] rs1Idx;
  logic [REG_ADDR_W-1:0] rs2Idx;
  logic [REG_ADDR_W-1:0] rdIdx;

  // Same field positions in every format that uses them
  assign rs1Idx = ins.iView.rs1;
  assign rs2Idx = ins.sView.rs2;
  assign rdIdx  = ins.iView.rd;

  // Combinational reads see a write one cycle later
  assign rd1 = regs[rs1Idx];
  assign rd2 = regs[rs2Idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && rdIdx != '0) begin  // Writes to x0 dropped
      regs[rdIdx] <= wd;
    end
  end

  // x0 storage held at zero so both ports read zero for it
  x0StaysZero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("x0 storage changed to %h", regs[0]);

endmodule

`default_nettype wire

//--- hw/fetchUnit.sv
// PC register and next-PC select
// Sequential, branch-if-zero and jump targets
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
  parameter logic [rvCorePkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       branch,
  input  logic                       jump,
  input  logic                       zero,
  input  logic [rvCorePkg::XLEN-1:0] branchOff,
  input  logic [rvCorePkg::XLEN-1:0] jumpOff,
  output logic [rvCorePkg::XLEN-1:0] pc
);

  import rvCorePkg::*;

  logic            takeBranch;
  logic [XLEN-1:0] pcOffset;   // Added to pc each cycle
  logic [XLEN-1:0] nextPc;

  // Beq-style test on the ALU zero after a SUB
  assign takeBranch = branch && zero;

  // Jump wins over branch
  always_comb begin
    if (jump) begin
      pcOffset = jumpOff;
    end else if (takeBranch) begin
      pcOffset = branchOff;
    end else begin
      pcOffset = XLEN'(4);  // Next word
    end
  end

  // Single adder for all three targets
  assign nextPc = pc + pcOffset;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= nextPc;
    end
  end

  // Offsets from decode must keep the PC on word boundaries
  pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc misaligned at %h", pc);

endmodule

`default_nettype wire

//--- hw/dataMem.sv
// Word-addressed data memory
// Sync write, read gated by memRead
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
  parameter int MEM_WORDS = 64
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       memRead,
  input  logic                       memWrite,
  input  logic [rvCorePkg::XLEN-1:0] addr,
  input  logic [rvCorePkg::XLEN-1:0] wd,
  output logic [rvCorePkg::XLEN-1:0] memOut
);

  import rvCorePkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [XLEN-1:0]  mem [MEM_WORDS];
  logic [IDX_W-1:0] wordIdx;

  // Byte address to word index, wraps at the memory depth
  assign wordIdx = IDX_W'((addr >> 2) % MEM_WORDS);

  // Zero when not reading, keeps writeback clean
  assign memOut = memRead ? mem[wordIdx] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (memWrite) begin
      mem[wordIdx] <= wd;
    end
  end

  // Load and store strobes from the same instruction are illegal
  noReadWrite: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
    else $error("memRead and memWrite both set");

  wordAccess: assert property (@(posedge clk) disable iff (rst)
    (memRead || memWrite) |-> addr[1:0] == 2'b00)
    else $error("unaligned access at %h", addr);

endmodule

`default_nettype wire

//--- hw/rvDatapath.sv
// Single-cycle RV32I-subset datapath top
// Fetch, decode, execute, memory and writeback wiring, operand and writeback selects
`timescale 1ns/1ps
`default_nettype none

module rvDatapath #(
  parameter int                         MEM_WORDS = 64,
  parameter logic [rvCorePkg::XLEN-1:0] RESET_PC  = '0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  rvCorePkg::insnWordT        ins,
  input  logic [2:0]                 aluOp,
  input  logic                       aluSrc,    // 1 selects the immediate
  input  logic                       memRead,
  input  logic                       memWrite,
  input  logic                       memToReg,  // 1 writes back the load
  input  logic                       regWrite,
  input  logic                       branch,
  input  logic                       jump,
  output logic [rvCorePkg::XLEN-1:0] pc,
  output logic [rvCorePkg::XLEN-1:0] aluResult,
  output logic                       zero,
  output logic [rvCorePkg::XLEN-1:0] wbData
);

  import rvCorePkg::*;

  logic [XLEN-1:0] rd1;
  logic [XLEN-1:0] rd2;
  logic [XLEN-1:0] immOut;
  logic [XLEN-1:0] branchOff;
  logic [XLEN-1:0] jumpOff;
  logic [XLEN-1:0] aluB;     // Second ALU operand
  logic [XLEN-1:0] memOut;

  fetchUnit #(.RESET_PC(RESET_PC)) fetch_i (
    .clk       (clk),
    .rst       (rst),
    .branch    (branch),
    .jump      (jump),
    .zero      (zero),
    .branchOff (branchOff),
    .jumpOff   (jumpOff),
    .pc        (pc)
  );

  // Decode stage
  regFile regs_i (
    .clk      (clk),
    .rst      (rst),
    .regWrite (regWrite),
    .ins      (ins),
    .wd       (wbData),  // Writeback loop
    .rd1      (rd1),
    .rd2      (rd2)
  );

  immGen imm_i (
    .ins       (ins),
    .immOut    (immOut),
    .branchOff (branchOff),
    .jumpOff   (jumpOff)
  );

  // Execute stage operand select
  assign aluB = aluSrc ? immOut : rd2;

  aluUnit alu_i (
    .a      (rd1),
    .b      (aluB),
    .aluOp  (aluOp),
    .result (aluResult),
    .zero   (zero)
  );

  // ALU result is the address, rs2 is the store data
  dataMem #(.MEM_WORDS(MEM_WORDS)) dmem_i (
    .clk      (clk),
    .rst      (rst),
    .memRead  (memRead),
    .memWrite (memWrite),
    .addr     (aluResult),
    .wd       (rd2),
    .memOut   (memOut)
  );

  // Writeback select
  assign wbData = memToReg ? memOut : aluResult;

endmodule

`default_nettype wire

//--- verification/stepTable.svh
// Instruction steps for the datapath testbench
// Rows give name, word, ALU code, strobes, expected wbData, zero and next pc
// Memory rows add the expected ALU address ahead of wbData
`ifndef STEP_TABLE_SVH
`define STEP_TABLE_SVH

task automatic fillStepTable();
  logic [11:0]     immA;   // Random I-format immediates
  logic [11:0]     immB;
  logic [XLEN-1:0] valA;
  logic [XLEN-1:0] valB;
  logic [XLEN-1:0] diff;
  logic [XLEN-1:0] less;

  addStep("reset x0 read", rType(0, 0, 0), ALU_ADD, CTL_NONE, 32'h0, 1'b1, 32'd4);
  // Constants x1=100 x2=-37 x3=100 x4=0x5A5
  addStep("addi x1", iType(OPC_OPIMM, 1, 0, 100), ALU_ADD, CTL_IMM, 32'd100, 1'b0, 32'd8);
  addStep("addi x2", iType(OPC_OPIMM, 2, 0, -37), ALU_ADD, CTL_IMM, 32'hFFFFFFDB, 1'b0, 32'd12);
  addStep("addi x3", iType(OPC_OPIMM, 3, 0, 100), ALU_ADD, CTL_IMM, 32'd100, 1'b0, 32'd16);
  addStep("addi x4", iType(OPC_OPIMM, 4, 0, 'h5A5), ALU_ADD, CTL_IMM, 32'h5A5, 1'b0, 32'd20);
  addStep("and x6", rType(6, 1, 4), ALU_AND, CTL_REG, 32'h024, 1'b0, 32'd24);
  addStep("or x7", rType(7, 1, 4), ALU_OR, CTL_REG, 32'h5E5, 1'b0, 32'd28);
  addStep("add x8", rType(8, 1, 2), ALU_ADD, CTL_REG, 32'd63, 1'b0, 32'd32);
  addStep("sub equal", rType(9, 1, 3), ALU_SUB, CTL_REG, 32'h0, 1'b1, 32'd36);
  addStep("sub negative", rType(9, 2, 1), ALU_SUB, CTL_REG, 32'hFFFFFF77, 1'b0, 32'd40);
  // Mixed signs and then equal signs
  addStep("slt neg<pos", rType(10, 2, 1), ALU_SLT, CTL_REG, 32'd1, 1'b0, 32'd44);
  addStep("slt pos<neg", rType(10, 1, 2), ALU_SLT, CTL_REG, 32'd0, 1'b1, 32'd48);
  addStep("slt pos<pos", rType(10, 1, 4), ALU_SLT, CTL_REG, 32'd1, 1'b0, 32'd52);
  addStep("addi x11", iType(OPC_OPIMM, 11, 0, -500), ALU_ADD, CTL_IMM, 32'hFFFFFE0C, 1'b0,
          32'd56);
  addStep("slt neg<neg", rType(12, 11, 2), ALU_SLT, CTL_REG, 32'd1, 1'b0, 32'd60);
  addStep("slt neg>neg", rType(12, 2, 11), ALU_SLT, CTL_REG, 32'd0, 1'b1, 32'd64);
  // Write to x0 shows on wbData but is dropped
  addStep("addi x0", iType(OPC_OPIMM, 0, 0, 55), ALU_ADD, CTL_IMM, 32'd55, 1'b0, 32'd68);
  addStep("x0 still zero", rType(13, 0, 0), ALU_ADD, CTL_REG, 32'h0, 1'b1, 32'd72);
  addStep("addi x5 base", iType(OPC_OPIMM, 5, 0, 'h100), ALU_ADD, CTL_IMM, 32'h100, 1'b0, 32'd76);
  addStep("sw x4,-8(x5)", sType(5, 4, -8), ALU_ADD, CTL_STORE, 32'hF8, 1'b0, 32'd80);
  addMemStep("lw x14,-8(x5)", iType(OPC_LOAD, 14, 5, -8), ALU_ADD, CTL_LOAD, 32'hF8, 32'h5A5,
             1'b0, 32'd84);  // Address 0xF8 on aluResult
  addStep("read x14", rType(15, 14, 0), ALU_ADD, CTL_REG, 32'h5A5, 1'b0, 32'd88);
  addStep("beq taken", bType(1, 3, 16), ALU_SUB, CTL_BRANCH, 32'h0, 1'b1, 32'd104);
  addStep("beq not taken", bType(1, 2, 16), ALU_SUB, CTL_BRANCH, 32'd137, 1'b0, 32'd108);
  // Word decodes to rs1=x31 and rs2=x25 which are still zero
  addStep("jal back 8", jType(0, -8), ALU_AND, CTL_JUMP, 32'h0, 1'b1, 32'd100);

  immA = 12'($random(seed));
  immB = 12'($random(seed));
  valA = {{(XLEN-12){immA[11]}}, immA};  // I-format sign extension
  valB = {{(XLEN-12){immB[11]}}, immB};
  diff = valA - valB;
  less = ($signed(valA) < $signed(valB)) ? 32'd1 : 32'd0;
  addStep("addi x16 rand", iType(OPC_OPIMM, 16, 0, int'(immA)), ALU_ADD, CTL_IMM, valA,
          valA == '0, 32'd104);
  addStep("addi x17 rand", iType(OPC_OPIMM, 17, 0, int'(immB)), ALU_ADD, CTL_IMM, valB,
          valB == '0, 32'd108);
  addStep("sub rand", rType(18, 16, 17), ALU_SUB, CTL_REG, diff, diff == '0, 32'd112);
  addStep("slt rand", rType(19, 16, 17), ALU_SLT, CTL_REG, less, less == '0, 32'd116);
endtask

`endif

//--- verification/rvDatapathTb.sv
// Testbench for the single-cycle datapath
// Step table applied in a loop with aluResult, wbData, zero and pc checks and a watchdog
`timescale 1ns/1ps
`default_nettype none

module rvDatapathTb;

  import rvCorePkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_STEPS    = 29;
  localparam int WATCHDOG_NS  = (NUM_STEPS + RESET_CYCLES + 20) * CLK_PERIOD;  // 20 spare cycles
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Opcodes of which the datapath only looks at bit 5
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Strobes as {aluSrc, memRead, memWrite, memToReg, regWrite, branch, jump}
  localparam logic [6:0] CTL_NONE   = 7'b0000000;
  localparam logic [6:0] CTL_REG    = 7'b0000100;
  localparam logic [6:0] CTL_IMM    = 7'b1000100;
  localparam logic [6:0] CTL_STORE  = 7'b1010000;
  localparam logic [6:0] CTL_LOAD   = 7'b1101100;
  localparam logic [6:0] CTL_BRANCH = 7'b0000010;
  localparam logic [6:0] CTL_JUMP   = 7'b0000001;

  typedef struct packed {
    insnWordT        ins;
    logic [2:0]      aluOp;
    logic [6:0]      ctl;
    logic [XLEN-1:0] expAlu;   // aluResult or the address on memory rows
    logic [XLEN-1:0] expWb;
    logic            expZero;
    logic [XLEN-1:0] expPc;    // pc after this step's edge
  } stepT;

  logic            clk;
  logic            rst;
  insnWordT        ins;
  logic [2:0]      aluOp;
  logic            aluSrc;
  logic            memRead;
  logic            memWrite;
  logic            memToReg;
  logic            regWrite;
  logic            branch;
  logic            jump;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] aluResult;
  logic [XLEN-1:0] wbData;
  logic            zero;

  stepT  stepTab [NUM_STEPS];
  string stepName [NUM_STEPS];
  int    fillIdx = 0;
  int    seed = 32'h1e84cdd5;
  int    errCount = 0;
  int    checkCount = 0;
  int    passCount = 0;
  int    stepErrStart = 0;  // errCount when the current step began

  rvDatapath #(.MEM_WORDS(64), .RESET_PC(RESET_PC)) dut_i (
    .clk(clk), .rst(rst), .ins(ins), .aluOp(aluOp),
    .aluSrc(aluSrc), .memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
    .regWrite(regWrite), .branch(branch), .jump(jump),
    .pc(pc), .aluResult(aluResult), .zero(zero), .wbData(wbData)
  );

  // Register-register word with rd under sView.immLo
  function automatic insnWordT rType(input int rd, input int rs1, input int rs2);
    insnWordT w;
    w = '0;
    w.sView.rs2    = 5'(rs2);
    w.sView.rs1    = 5'(rs1);
    w.iView.rd     = 5'(rd);
    w.iView.opcode = OPC_OP;
    return w;
  endfunction

  function automatic insnWordT iType(input logic [6:0] opc, input int rd, input int rs1,
                                     input int imm);
    insnWordT w;
    w = '0;
    w.iView.imm12  = 12'(imm);  // Low 12 bits with the sign in bit 11
    w.iView.rs1    = 5'(rs1);
    w.iView.rd     = 5'(rd);
    w.iView.opcode = opc;
    return w;
  endfunction

  function automatic insnWordT sType(input int rs1, input int rs2, input int imm);
    insnWordT    w;
    logic [11:0] o;
    o = 12'(imm);
    w = '0;
    w.sView.immHi  = o[11:5];
    w.sView.rs2    = 5'(rs2);
    w.sView.rs1    = 5'(rs1);
    w.sView.immLo  = o[4:0];
    w.sView.opcode = OPC_STORE;
    return w;
  endfunction

  function automatic insnWordT bType(input int rs1, input int rs2, input int off);
    insnWordT    w;
    logic [12:0] o;
    o = 13'(off);
    w = '0;
    w.bView.sign     = o[12];
    w.bView.imm11    = o[11];
    w.bView.imm10to5 = o[10:5];
    w.bView.imm4to1  = o[4:1];
    w.bView.rs2      = 5'(rs2);
    w.bView.rs1      = 5'(rs1);
    w.bView.opcode   = OPC_BRANCH;
    return w;
  endfunction

  function automatic insnWordT jType(input int rd, input int off);
    insnWordT    w;
    logic [20:0] o;
    o = 21'(off);
    w = '0;
    w.jView.sign      = o[20];
    w.jView.imm19to12 = o[19:12];
    w.jView.imm11     = o[11];
    w.jView.imm10to1  = o[10:1];
    w.jView.rd        = 5'(rd);
    w.jView.opcode    = OPC_JAL;
    return w;
  endfunction

  // Row with its own expected ALU result, the address of a load
  task automatic addMemStep(input string name, input insnWordT w, input logic [2:0] op,
                            input logic [6:0] ctl, input logic [XLEN-1:0] expAlu,
                            input logic [XLEN-1:0] expWb, input logic expZero,
                            input logic [XLEN-1:0] expPc);
    if (fillIdx < NUM_STEPS) begin
      stepTab[fillIdx]  = '{w, op, ctl, expAlu, expWb, expZero, expPc};
      stepName[fillIdx] = name;
    end
    fillIdx++;
  endtask

  // Rows where aluResult and wbData agree
  task automatic addStep(input string name, input insnWordT w, input logic [2:0] op,
                         input logic [6:0] ctl, input logic [XLEN-1:0] expWb,
                         input logic expZero, input logic [XLEN-1:0] expPc);
    addMemStep(name, w, op, ctl, expWb, expWb, expZero, expPc);
  endtask

  `include "stepTable.svh"

  task automatic checkValue(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic applyStep(input stepT s);
    ins   <= s.ins;
    aluOp <= s.aluOp;
    {aluSrc, memRead, memWrite, memToReg, regWrite, branch, jump} <= s.ctl;
  endtask

  // Closing pc check of a step and its result line
  task automatic finishStep(input int idx);
    checkValue(pc, stepTab[idx].expPc, $sformatf("%s next pc", stepName[idx]));
    if (errCount == stepErrStart) begin
      passCount++;
      $display("step %0d %s: pass", idx, stepName[idx]);
    end else begin
      $display("step %0d %s: fail, %0d errors", idx, stepName[idx], errCount - stepErrStart);
    end
    stepErrStart = errCount;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns, a step never finished", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst   = 1'b1;
    ins   = '0;
    aluOp = ALU_AND;
    {aluSrc, memRead, memWrite, memToReg, regWrite, branch, jump} = CTL_NONE;
    fillStepTable();
    if (fillIdx != NUM_STEPS) begin
      $display("step table holds %0d rows but the run expects %0d", fillIdx, NUM_STEPS);
      errCount++;
      fillIdx = (fillIdx > NUM_STEPS) ? NUM_STEPS : fillIdx;
    end
    stepErrStart = errCount;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    for (int i = 0; i < fillIdx; i++) begin
      @(posedge clk);
      rst <= 1'b0;  // Fifth edge still sees reset and the first step follows
      applyStep(stepTab[i]);
      @(negedge clk);  // Mid-cycle where combinational outputs have settled
      if (i == 0) begin
        checkValue(pc, RESET_PC, "pc out of reset");
      end else begin
        finishStep(i - 1);
      end
      checkValue(aluResult, stepTab[i].expAlu, $sformatf("%s aluResult", stepName[i]));
      checkValue(wbData, stepTab[i].expWb, $sformatf("%s wbData", stepName[i]));
      checkValue({31'b0, zero}, {31'b0, stepTab[i].expZero},
                 $sformatf("%s zero", stepName[i]));
    end
    @(posedge clk);
    ins   <= '0;  // Idle word with no writes
    aluOp <= ALU_AND;
    {aluSrc, memRead, memWrite, memToReg, regWrite, branch, jump} <= CTL_NONE;
    @(negedge clk);
    if (fillIdx > 0) begin
      finishStep(fillIdx - 1);
    end
    $display("steps passed %0d of %0d, checks %0d, errors %0d",
             passCount, fillIdx, checkCount, errCount);
    if (errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verification
hw/rvCorePkg.sv
hw/aluUnit.sv
hw/immGen.sv
hw/regFile.sv
hw/fetchUnit.sv
hw/dataMem.sv
hw/rvDatapath.sv
verification/rvDatapathTb.sv

//--- run.sh
#!/bin/sh
# Builds the datapath testbench with Verilator and runs it
# Exit status follows the result line found in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=rvDatapathSim

verilator --binary --timing --assert -f compile.f --top-module rvDatapathTb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" "$LOG"; then
  echo "result: passed"
  exit 0
else
  echo "result: failed"
  exit 1
fi
